//--- Bender.yml
package:
  name: debug_bridge

sources:
  - common/debug_bridge_pkg.sv
  - ahb/ahb_slave_port.sv
  - adiv5/adiv5_cmd_sequencer.sv
  - adiv5/adiv5_resp_tracker.sv
  - rtl/debug_bridge_top.sv
  - target: simulation
    files:
      - sim/debug_bridge_checker.sv
      - sim/tb_debug_bridge.sv

//--- adiv5/adiv5_cmd_sequencer.sv
// ADIv5 command sequencer: issues SELECT, CSW, TAR and DRW writes with CSW and TAR caching
`timescale 1ns/10ps
module adiv5_cmd_sequencer import debug_bridge_pkg::*;
(
   input  logic        CLK,
   input  logic        rst_n,
   input  logic        enable,
   input  logic        seq,
   input  logic [7:0]  apsel,
   input  logic        req,
   input  ahb_req_t    req_data,
   input  logic        room,
   input  logic        err_pulse,
   output logic        ack,
   output adiv5_cmd_t  cmd_wrdata,
   output logic        cmd_wren,
   output logic        issue
);

   seq_state_e  state;
   logic        csw_init;
   logic [1:0]  csw_size;
   logic        csw_inc;
   logic [31:0] tar;
   logic        tar_valid;
   logic [1:0]  new_size;
   logic        tar_hit;
   logic [31:0] tar_inc;

   // Startup CSW is always word sized
   assign new_size = csw_init ? SIZE_WORD : req_data.size;
   assign tar_hit  = tar_valid && (tar == req_data.addr);
   assign tar_inc  = tar + (32'd1 << req_data.size);
   assign issue    = cmd_wren;

   always_comb
   begin
      cmd_wrdata = make_cmd(1'b1, ~req_data.write, reg_drw, req_data.wdata);
      cmd_wren   = 1'b0;
      case (state)
         st_select:
         begin
            // AP bank 0 and DP bank 0
            cmd_wrdata = make_cmd(1'b0, 1'b0, reg_select, {apsel, 24'h0});
            cmd_wren   = room;
         end
         st_csw:
         begin
            cmd_wrdata = make_cmd(1'b1, 1'b0, reg_csw, csw_value(new_size, seq));
            cmd_wren   = room;
         end
         st_tar:
         begin
            cmd_wrdata = make_cmd(1'b1, 1'b0, reg_tar, req_data.addr);
            cmd_wren   = room;
         end
         st_drw:
            cmd_wren = room;
         default:
            cmd_wren = 1'b0;
      endcase
   end

   always_ff @(posedge CLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= st_disabled;
         ack       <= 1'b0;
         csw_init  <= 1'b0;
         csw_size  <= SIZE_WORD;
         csw_inc   <= 1'b0;
         tar_valid <= 1'b0;
      end
      else
      begin
         case (state)
            st_disabled:
            begin
               tar_valid <= 1'b0;
               if (enable)
                  state <= st_select;
            end
            st_select:
            begin
               if (room)
               begin
                  csw_init <= 1'b1;
                  state    <= st_csw;
               end
            end
            st_idle:
            begin
               if (!enable)
                  state <= st_disabled;
               else if (req && !ack)
               begin
                  if (req_data.size != csw_size || seq != csw_inc)
                     state <= st_csw;
                  else if (!tar_hit)
                     state <= st_tar;
                  else
                     state <= st_drw;
               end
            end
            st_csw:
            begin
               if (room)
               begin
                  csw_size <= new_size;
                  csw_inc  <= seq;
                  csw_init <= 1'b0;
                  if (csw_init)
                     state <= st_idle;
                  else if (tar_hit)
                     state <= st_drw;
                  else
                     state <= st_tar;
               end
            end
            st_tar:
            begin
               if (room)
               begin
                  tar       <= req_data.addr;
                  tar_valid <= 1'b1;
                  state     <= st_drw;
               end
            end
            st_drw:
            begin
               if (room)
               begin
                  ack   <= 1'b1;
                  state <= st_done;
                  if (csw_inc)
                  begin
                     tar <= tar_inc;
                     // Auto-increment is only guaranteed inside a 1KB block
                     if (tar_inc[9:0] == 10'h0)
                        tar_valid <= 1'b0;
                  end
               end
            end
            st_done:
            begin
               if (!req)
               begin
                  ack   <= 1'b0;
                  state <= st_idle;
               end
            end
            default:
               state <= st_disabled;
         endcase

         // A failed access leaves the target TAR unknown
         if (err_pulse)
            tar_valid <= 1'b0;
      end
   end

endmodule

//--- adiv5/adiv5_resp_tracker.sv
// ADIv5 response tracker: counts outstanding commands, keeps last read data and sticky status
`timescale 1ns/10ps
module adiv5_resp_tracker import debug_bridge_pkg::*;
#(
   parameter int CTR_WIDTH = 3
)
(
   input  logic        CLK,
   input  logic        rst_n,
   input  logic        enable,
   input  logic        issue,
   input  logic        cmd_full,
   input  adiv5_resp_t resp_rddata,
   input  logic        resp_empty,
   output logic        resp_rden,
   output logic        room,
   output logic        idle,
   output logic [31:0] last_data,
   output logic        err_sticky,
   output logic        err_pulse,
   output adiv5_stat_e stat
);

   logic [CTR_WIDTH-1:0] issued;
   logic [CTR_WIDTH-1:0] received;
   logic [CTR_WIDTH-1:0] issued_next;
   logic                 resp_bad;

   // Head word is taken as soon as it shows up
   assign resp_rden   = ~resp_empty;
   assign issued_next = issued + 1'b1;
   // Stop one short of wrapping onto the received count
   assign room        = ~cmd_full && (issued_next != received);
   assign idle        = (issued == received);
   assign resp_bad    = resp_rden && (resp_rddata.stat != stat_ok);

   always_ff @(posedge CLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         issued   <= '0;
         received <= '0;
      end
      else
      begin
         if (issue)
            issued <= issued_next;
         if (resp_rden)
            received <= received + 1'b1;
      end
   end

   always_ff @(posedge CLK)
   begin
      if (resp_rden)
         last_data <= resp_rddata.data;
   end

   always_ff @(posedge CLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         stat       <= stat_ok;
         err_sticky <= 1'b0;
         err_pulse  <= 1'b0;
      end
      else
      begin
         err_pulse <= resp_bad;
         // First failure is kept until the bridge is disabled
         if (!enable)
         begin
            stat       <= stat_ok;
            err_sticky <= 1'b0;
         end
         else if (resp_bad && !err_sticky)
         begin
            stat       <= adiv5_stat_e'(resp_rddata.stat);
            err_sticky <= 1'b1;
         end
      end
   end

endmodule

//--- ahb/ahb_slave_port.sv
// AHB-Lite slave front end: captures transfers, hands them to the sequencer, drives the response
`timescale 1ns/10ps
module ahb_slave_port import debug_bridge_pkg::*;
(
   input  logic        CLK,
   input  logic        rst_n,
   input  logic        enable,
   input  logic        HSEL,
   input  logic        HREADY,
   input  ahb_htrans_e HTRANS,
   input  logic        HWRITE,
   input  logic [2:0]  HSIZE,
   input  logic [31:0] HADDR,
   input  logic [31:0] HWDATA,
   input  logic        ack,
   input  logic        idle,
   input  logic [31:0] last_data,
   input  logic        err_sticky,
   output logic        HREADYOUT,
   output logic        HRESP,
   output logic [31:0] HRDATA,
   output logic        req,
   output ahb_req_t    req_data
);

   typedef enum logic [2:0]
   {
      fe_idle, fe_data, fe_req, fe_wait, fe_err
   } fe_state_e;

   fe_state_e state;
   logic      accept;
   logic      reject;
   logic      done;

   assign accept = HSEL && HREADY && (HTRANS == htrans_nonseq || HTRANS == htrans_seq);

   // All commands of the transfer answered
   assign done = ack && idle;

   always_ff @(posedge CLK)
   begin
      if (state == fe_idle && accept)
      begin
         req_data.write <= HWRITE;
         req_data.size  <= HSIZE[1:0];
         req_data.addr  <= HADDR;
      end
      // Data phase follows the accepting cycle
      if (state == fe_data)
         req_data.wdata <= HWDATA;
      if (state == fe_wait && done && !err_sticky && !req_data.write)
         HRDATA <= last_data;
   end

   always_ff @(posedge CLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= fe_idle;
         HREADYOUT <= 1'b1;
         HRESP     <= 1'b0;
         req       <= 1'b0;
         reject    <= 1'b0;
      end
      else
      begin
         case (state)
            fe_idle:
            begin
               // Ends the second error cycle
               HRESP <= 1'b0;
               if (accept)
               begin
                  HREADYOUT <= 1'b0;
                  // Disabled bridge or transfers wider than a word get the error response
                  reject    <= !enable || HSIZE[2] || (HSIZE[1:0] == 2'b11);
                  state     <= fe_data;
               end
            end
            fe_data:
            begin
               if (reject)
               begin
                  HRESP <= 1'b1;
                  state <= fe_err;
               end
               else
                  state <= fe_req;
            end
            fe_req:
            begin
               // Previous handshake must be fully closed
               if (!ack)
               begin
                  req   <= 1'b1;
                  state <= fe_wait;
               end
            end
            fe_wait:
            begin
               if (done)
               begin
                  req <= 1'b0;
                  if (err_sticky)
                  begin
                     HRESP <= 1'b1;
                     state <= fe_err;
                  end
                  else
                  begin
                     HREADYOUT <= 1'b1;
                     state     <= fe_idle;
                  end
               end
            end
            fe_err:
            begin
               HREADYOUT <= 1'b1;
               state     <= fe_idle;
            end
            default:
               state <= fe_idle;
         endcase
      end
   end

endmodule

//--- common/debug_bridge_pkg.sv
// Debug bridge shared types: ADIv5 command and response formats, enums and constants
package debug_bridge_pkg;

   // ADIv5 register addresses, A[3:0] of the DP/AP access
   typedef enum logic [3:0]
   {
      reg_csw    = 4'h0,
      reg_tar    = 4'h4,
      reg_select = 4'h8,
      reg_drw    = 4'hc
   } adiv5_reg_e;

   // Acknowledge codes as returned by the probe
   typedef enum logic [2:0]
   {
      stat_ok    = 3'd1,
      stat_wait  = 3'd2,
      stat_fault = 3'd4
   } adiv5_stat_e;

   // One word of the command FIFO
   typedef struct packed
   {
      logic        ap_ndp;
      logic        rnw;
      adiv5_reg_e  addr;
      logic [31:0] data;
   } adiv5_cmd_t;

   // One word of the response FIFO
   typedef struct packed
   {
      logic [31:0] data;
      logic [2:0]  stat;
   } adiv5_resp_t;

   // Transfer handed from the AHB front end to the sequencer
   typedef struct packed
   {
      logic        write;
      logic [1:0]  size;
      logic [31:0] addr;
      logic [31:0] wdata;
   } ahb_req_t;

   typedef enum logic [2:0]
   {
      st_disabled, st_select, st_idle, st_csw, st_tar, st_drw, st_done
   } seq_state_e;

   typedef enum logic [1:0]
   {
      htrans_idle   = 2'b00,
      htrans_busy   = 2'b01,
      htrans_nonseq = 2'b10,
      htrans_seq    = 2'b11
   } ahb_htrans_e;

   // CSW with Size[2:0] and AddrInc[5:4] cleared, DeviceEn and a default Prot set
   localparam logic [31:0] CSW_BASE       = 32'h2300_0040;
   localparam logic [1:0]  CSW_INC_OFF    = 2'b00;
   localparam logic [1:0]  CSW_INC_SINGLE = 2'b01;
   localparam logic [1:0]  SIZE_WORD      = 2'd2;

   function automatic logic [31:0] csw_value(input logic [1:0] size, input logic inc);
      csw_value = CSW_BASE | {26'h0, (inc ? CSW_INC_SINGLE : CSW_INC_OFF), 2'b00, size};
   endfunction

   function automatic adiv5_cmd_t make_cmd(input logic ap, input logic rd,
                                           input adiv5_reg_e addr, input logic [31:0] data);
      adiv5_cmd_t cmd;
      cmd.ap_ndp = ap;
      cmd.rnw    = rd;
      cmd.addr   = addr;
      cmd.data   = data;
      return cmd;
   endfunction

endpackage

//--- rtl/debug_bridge_top.sv
// Debug bridge top level: AHB-Lite slave to ADIv5 memory access through external FIFOs
`timescale 1ns/10ps
module debug_bridge_top import debug_bridge_pkg::*;
#(
   parameter int CTR_WIDTH = 3
)
(
   input  logic        CLK,
   input  logic        rst_n,
   input  logic        enable,
   input  logic        seq,
   input  logic [7:0]  apsel,
   output adiv5_stat_e stat,
   input  logic        HSEL,
   input  logic        HREADY,
   input  logic [1:0]  HTRANS,
   input  logic        HWRITE,
   input  logic [2:0]  HSIZE,
   input  logic [31:0] HADDR,
   input  logic [31:0] HWDATA,
   output logic        HREADYOUT,
   output logic        HRESP,
   output logic [31:0] HRDATA,
   output adiv5_cmd_t  cmd_wrdata,
   output logic        cmd_wren,
   input  logic        cmd_full,
   input  adiv5_resp_t resp_rddata,
   input  logic        resp_empty,
   output logic        resp_rden
);

   // Front end to sequencer handshake
   logic        req;
   logic        ack;
   ahb_req_t    req_data;

   // Tracker results
   logic        room;
   logic        issue;
   logic        idle;
   logic        err_sticky;
   logic        err_pulse;
   logic [31:0] last_data;

   ahb_slave_port u_ahb_slave_port
   (
      .CLK, .rst_n, .enable,
      .HSEL, .HREADY,
      .HTRANS     (ahb_htrans_e'(HTRANS)),
      .HWRITE, .HSIZE, .HADDR, .HWDATA,
      .ack, .idle, .last_data, .err_sticky,
      .HREADYOUT, .HRESP, .HRDATA,
      .req, .req_data
   );

   adiv5_cmd_sequencer u_cmd_sequencer
   (
      .CLK, .rst_n, .enable, .seq, .apsel,
      .req, .req_data, .room, .err_pulse,
      .ack, .cmd_wrdata, .cmd_wren, .issue
   );

   adiv5_resp_tracker #(.CTR_WIDTH(CTR_WIDTH)) u_resp_tracker
   (
      .CLK, .rst_n, .enable, .issue, .cmd_full,
      .resp_rddata, .resp_empty, .resp_rden,
      .room, .idle, .last_data, .err_sticky, .err_pulse, .stat
   );

endmodule

//--- sim.f
common/debug_bridge_pkg.sv
ahb/ahb_slave_port.sv
adiv5/adiv5_cmd_sequencer.sv
adiv5/adiv5_resp_tracker.sv
rtl/debug_bridge_top.sv
sim/debug_bridge_checker.sv
sim/tb_debug_bridge.sv

//--- sim/debug_bridge_checker.sv
// Protocol checker bound into the debug bridge top level
`timescale 1ns/10ps
module debug_bridge_checker
(
   input logic       CLK,
   input logic       rst_n,
   input logic       HSEL,
   input logic       HREADY,
   input logic [1:0] HTRANS,
   input logic       HREADYOUT,
   input logic       HRESP,
   input logic       cmd_wren,
   input logic       cmd_full
);

   int fail_count = 0;

   // Command FIFO is never written while full
   no_write_when_full: assert property (@(posedge CLK) disable iff (!rst_n)
      !(cmd_wren && cmd_full))
   else
   begin
      $error("cmd_wren high while cmd_full is high");
      fail_count++;
   end

   // Two-cycle error with HREADYOUT low then high
   two_cycle_error: assert property (@(posedge CLK) disable iff (!rst_n)
      $rose(HRESP) |-> !HREADYOUT ##1 (HRESP && HREADYOUT) ##1 !HRESP)
   else
   begin
      $error("HRESP error response is not two cycles long");
      fail_count++;
   end

   wait_after_accept: assert property (@(posedge CLK) disable iff (!rst_n)
      (HSEL && HREADY && HTRANS[1] && HREADYOUT) |=> !HREADYOUT)
   else
   begin
      $error("HREADYOUT did not fall after an accepted transfer");
      fail_count++;
   end

endmodule

bind debug_bridge_top debug_bridge_checker u_checker (.*);

//--- sim/tb_debug_bridge.sv
// Debug bridge testbench with AHB master, behavioral ADIv5 target and data checks
`timescale 1ns/10ps
module tb_debug_bridge import debug_bridge_pkg::*;
();

   localparam int          TIMEOUT    = 400;
   localparam logic [31:0] FAULT_ADDR = 32'h4000_0ff0;

   logic        CLK = 1'b0;
   logic        rst_n;
   logic        enable;
   logic        seq;
   logic [7:0]  apsel;
   adiv5_stat_e stat;
   logic        HSEL;
   logic        HREADY;
   logic [1:0]  HTRANS;
   logic        HWRITE;
   logic [2:0]  HSIZE;
   logic [31:0] HADDR;
   logic [31:0] HWDATA;
   logic        HREADYOUT;
   logic        HRESP;
   logic [31:0] HRDATA;
   adiv5_cmd_t  cmd_wrdata;
   logic        cmd_wren;
   logic        cmd_full;
   adiv5_resp_t resp_rddata;
   logic        resp_empty;
   logic        resp_rden;

   // Target state and expected memory keyed by word address
   logic [31:0] tgt_mem [logic [31:0]];
   logic [31:0] exp_mem [logic [31:0]];
   logic [31:0] tgt_csw;
   logic [31:0] tgt_tar;
   adiv5_resp_t resp_q [$];
   int          ready_q [$];
   adiv5_cmd_t  cmd_log [$];
   int          cyc;
   logic        stress;
   string       test_name;
   int          checks;
   int          errors;
   int          test_errors;
   int          tests;

   debug_bridge_top #(.CTR_WIDTH(3)) UUT (.*);

   always #2 CLK = ~CLK;

   // Power-up content that differs for every word
   function automatic logic [31:0] fill_word(input logic [31:0] w);
      return {w[29:0], 2'b10} ^ 32'h6c5a_3e01;
   endfunction

   // Byte lanes of an AHB or DRW transfer
   function automatic logic [31:0] lane_mask(input logic [1:0] size, input logic [1:0] lo);
      case (size)
         2'd0:    return 32'hff << (8 * lo);
         2'd1:    return 32'hffff << (16 * lo[1]);
         default: return 32'hffff_ffff;
      endcase
   endfunction

   function automatic int count_cmds(input adiv5_reg_e a);
      int n;
      n = 0;
      foreach (cmd_log[i])
         if (cmd_log[i].ap_ndp && cmd_log[i].addr == a)
            n++;
      return n;
   endfunction

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      $display("Test %s done with %0d errors", test_name, test_errors);
      errors += test_errors;
      tests++;
   endtask

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp)
      else
      begin
         $display("Fail %s: %s expected %h, actual %h", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond === 1'b1)
      else
      begin
         $display("Error in %s: %s", test_name, what);
         test_errors++;
      end
   endtask

   task automatic abort_run(input string why);
      $display("Timeout in %s: %s", test_name, why);
      $display("Simulation failed");
      $finish;
   endtask

   // Target side of one command and its queued response
   task automatic take_cmd(input adiv5_cmd_t c);
      adiv5_resp_t r;
      logic [31:0] w;
      logic [31:0] m;
      r.data = 32'h0;
      r.stat = stat_ok;
      w      = tgt_tar >> 2;
      m      = lane_mask(tgt_csw[1:0], tgt_tar[1:0]);
      cmd_log.push_back(c);
      if (c.ap_ndp && c.addr == reg_csw)
      begin
         check_value("CSW fixed fields", CSW_BASE, c.data & ~32'h37);
         tgt_csw = c.data;
      end
      else if (c.ap_ndp && c.addr == reg_tar)
         tgt_tar = c.data;
      else if (c.ap_ndp && c.addr == reg_drw)
      begin
         if (!tgt_mem.exists(w))
            tgt_mem[w] = fill_word(w);
         if (tgt_tar == FAULT_ADDR)
            r.stat = stat_fault;
         else if (c.rnw)
            r.data = tgt_mem[w];
         else
            tgt_mem[w] = (tgt_mem[w] & ~m) | (c.data & m);
         // Single increment by the transfer size
         if (tgt_csw[5:4] == 2'b01)
            tgt_tar = tgt_tar + (32'd1 << tgt_csw[2:0]);
      end
      resp_q.push_back(r);
      ready_q.push_back(cyc + $urandom_range(3));
   endtask

   always @(posedge CLK)
   begin
      cyc++;
      if (rst_n)
      begin
         check_true(resp_rden === !resp_empty, "resp_rden does not follow resp_empty");
         // Head word was pulled on this edge
         if (!resp_empty)
         begin
            resp_q.delete(0);
            ready_q.delete(0);
         end
         if (cmd_wren && !cmd_full)
            take_cmd(cmd_wrdata);
         if (resp_q.size() > 0 && cyc >= ready_q[0])
         begin
            resp_rddata <= resp_q[0];
            resp_empty  <= 1'b0;
         end
         else
            resp_empty <= 1'b1;
         cmd_full <= stress && ($urandom_range(2) == 0);
      end
   end

   // One AHB-Lite transfer returning its read data and whether HRESP was seen
   task automatic ahb_xfer(input logic write, input logic [1:0] size, input logic [31:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
      int n;
      n   = 0;
      err = 1'b0;
      @(posedge CLK);
      HSEL   <= 1'b1;
      HTRANS <= htrans_nonseq;
      HWRITE <= write;
      HSIZE  <= {1'b0, size};
      HADDR  <= addr;
      @(posedge CLK);
      HSEL   <= 1'b0;
      HTRANS <= htrans_idle;
      HWDATA <= wdata;
      do
      begin
         @(posedge CLK);
         err = err | HRESP;
         n++;
      end
      while (!HREADYOUT && n < TIMEOUT);
      if (!HREADYOUT)
         abort_run("HREADYOUT stayed low");
      rdata = HRDATA;
   endtask

   // Transfer that must succeed with reads compared on their byte lanes
   task automatic checked_access(input logic write, input logic [1:0] size,
                                 input logic [31:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      logic [31:0] m;
      logic [31:0] w;
      m = lane_mask(size, addr[1:0]);
      w = addr >> 2;
      ahb_xfer(write, size, addr, data, rd, err);
      check_true(!err, "unexpected error response");
      if (!exp_mem.exists(w))
         exp_mem[w] = fill_word(w);
      if (write)
         exp_mem[w] = (exp_mem[w] & ~m) | (data & m);
      else
         check_value("read data", exp_mem[w] & m, rd & m);
   endtask

   initial
   begin
      logic [31:0] rd;
      logic        err;
      logic [31:0] a;
      int          n;
      n           = $urandom(32'hf6b8);
      rst_n       = 1'b0;
      enable      = 1'b0;
      seq         = 1'b0;
      apsel       = 8'($urandom_range(255));
      HSEL        = 1'b0;
      HREADY      = 1'b1;
      HTRANS      = htrans_idle;
      HWRITE      = 1'b0;
      HSIZE       = 3'd0;
      HADDR       = 32'h0;
      HWDATA      = 32'h0;
      cmd_full    = 1'b0;
      resp_empty  = 1'b1;
      resp_rddata = '0;
      stress      = 1'b0;
      tgt_csw     = 32'h0;
      tgt_tar     = 32'h0;
      cyc         = 0;
      checks      = 0;
      errors      = 0;
      tests       = 0;
      repeat (16) @(posedge CLK);
      rst_n <= 1'b1;

      begin_test("disabled");
      @(posedge CLK);
      check_true(HREADYOUT && !HRESP && !cmd_wren && stat == stat_ok, "wrong values after reset");
      ahb_xfer(1'b1, SIZE_WORD, 32'h1000_0000, 32'h1234_5678, rd, err);
      check_true(err, "transfer while disabled got no error");
      check_true(cmd_log.size() == 0, "command issued while disabled");
      end_test();

      begin_test("startup");
      enable <= 1'b1;
      n = 0;
      while (cmd_log.size() < 2 && n < TIMEOUT)
      begin
         @(posedge CLK);
         n++;
      end
      if (cmd_log.size() < 2)
         abort_run("no startup commands after enable");
      check_true(!cmd_log[0].ap_ndp && cmd_log[0].addr == reg_select, "first command not SELECT");
      check_value("SELECT data", {apsel, 24'h0}, cmd_log[0].data);
      check_value("second command", reg_csw, cmd_log[1].addr);
      check_value("startup CSW size", SIZE_WORD, cmd_log[1].data & 32'h7);
      end_test();

      begin_test("word_rw");
      for (int i = 0; i < 8; i++)
      begin
         a = 32'h1000_0000 | ($urandom_range(255) << 2);
         checked_access(1'b1, SIZE_WORD, a, $urandom);
         checked_access(1'b0, SIZE_WORD, a, 32'h0);
      end
      end_test();

      begin_test("sub_word");
      for (int s = 0; s < 2; s++)
      begin
         a = 32'h1000_1000 | ($urandom_range(63) << s);
         checked_access(1'b1, SIZE_WORD, a & ~32'h3, $urandom);
         cmd_log.delete();
         checked_access(1'b1, 2'(s), a, $urandom);
         check_true(cmd_log.size() >= 2, "too few commands for a sub-word write");
         check_value("first command", reg_csw, cmd_log[0].addr);
         check_value("CSW size", s, cmd_log[0].data & 32'h7);
         check_value("last command", reg_drw, cmd_log[$].addr);
         checked_access(1'b0, 2'(s), a, 32'h0);
      end
      end_test();

      begin_test("auto_increment");
      seq <= 1'b1;
      cmd_log.delete();
      for (int i = 0; i < 4; i++)
         checked_access(1'b1, SIZE_WORD, 32'h1000_2000 + 4 * i, $urandom);
      check_value("TAR writes with seq high", 1, count_cmds(reg_tar));
      seq <= 1'b0;
      cmd_log.delete();
      for (int i = 0; i < 4; i++)
         checked_access(1'b0, SIZE_WORD, 32'h1000_2000 + 4 * i, 32'h0);
      check_value("TAR writes with seq low", 4, count_cmds(reg_tar));
      end_test();

      begin_test("backpressure");
      stress <= 1'b1;
      for (int i = 0; i < 12; i++)
      begin
         a = 32'h1000_3000 | ($urandom_range(63) << 2);
         checked_access(1'b1, 2'($urandom_range(2)), a, $urandom);
         checked_access(1'b0, SIZE_WORD, a, 32'h0);
      end
      stress <= 1'b0;
      end_test();

      begin_test("fault");
      ahb_xfer(1'b0, SIZE_WORD, FAULT_ADDR, 32'h0, rd, err);
      check_true(err, "fault access got no error");
      check_value("stat after fault", stat_fault, stat);
      ahb_xfer(1'b0, SIZE_WORD, 32'h1000_0000, 32'h0, rd, err);
      check_true(err, "transfer after fault got no error");
      enable <= 1'b0;
      repeat (4) @(posedge CLK);
      enable <= 1'b1;
      check_value("stat after disable", stat_ok, stat);
      checked_access(1'b0, SIZE_WORD, 32'h1000_0000, 32'h0);
      end_test();

      errors += UUT.u_checker.fail_count;
      $display("Tests: %0d, checks: %0d, errors: %0d (protocol assertion failures: %0d)",
               tests, checks, errors, UUT.u_checker.fail_count);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule
